/* design/cmd_shift_reg.sv */
`default_nettype none
`timescale 1ns/1ps

`include "testchip_params.svh"

module cmd_shift_reg (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       scan_en,
  input  logic                       scan_in,
  input  logic                       par_load,
  input  logic [`TC_CMD_W-1:0]       par_bits,
  input  logic                       mem_load,
  input  sram_macro_pkg::word_t      rd_data0,
  input  sram_macro_pkg::word_t      rd_data1,
  input  logic                       rd_valid0,
  input  logic                       rd_valid1,
  output sram_cmd_pkg::cmd_word_t    cmd,
  output logic                       scan_out,
  output sram_macro_pkg::word_t      data0,
  output sram_macro_pkg::word_t      data1,
  sram_port_if.ctrl                  banks [`TC_NUM_BANKS]
);

  sram_cmd_pkg::cmd_word_t cmd_q;

  // Scan wins over parallel load, which wins over the memory load
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= sram_cmd_pkg::CMD_RESET;
    end else if (scan_en) begin
      cmd_q <= sram_cmd_pkg::cmd_word_t'({cmd_q[`TC_CMD_W-2:0], scan_in}); // Shift left
    end else if (par_load) begin
      cmd_q <= sram_cmd_pkg::cmd_word_t'(par_bits);
    end else if (mem_load) begin
      // Only the din fields take read data
      if (rd_valid0) begin
        cmd_q.p0.din <= rd_data0;
      end
      if (rd_valid1) begin
        cmd_q.p1.din <= rd_data1;
      end
    end
  end

  assign cmd      = cmd_q;
  assign scan_out = cmd_q[`TC_CMD_W-1]; // MSB leaves first
  assign data0    = cmd_q.p0.din;
  assign data1    = cmd_q.p1.din;

  // Fan the port fields out to the selected bank only
  for (genvar g = 0; g < `TC_NUM_BANKS; g++) begin : sel_g
    logic hit;

    assign hit = (cmd_q.chip_select == `TC_CS_W'(g));

    assign banks[g].csb0   = hit ? cmd_q.p0.csb : 1'b1;
    assign banks[g].web0   = hit ? cmd_q.p0.web : 1'b1;   // Idle banks see a read
    assign banks[g].wmask0 = hit ? cmd_q.p0.wmask : '0;
    assign banks[g].addr0  = hit ? cmd_q.p0.addr[`TC_BANK_AW-1:0] : '0;
    assign banks[g].din0   = hit ? cmd_q.p0.din : '0;

    // Port 1 has no write path
    assign banks[g].csb1   = hit ? cmd_q.p1.csb : 1'b1;
    assign banks[g].addr1  = hit ? cmd_q.p1.addr[`TC_BANK_AW-1:0] : '0;
  end

endmodule

`default_nettype wire

/* design/read_capture.sv */
`default_nettype none
`timescale 1ns/1ps

`include "testchip_params.svh"

module read_capture (
  input  logic                    clk,
  input  logic                    reset,
  input  sram_cmd_pkg::cmd_word_t cmd,
  sram_port_if.mon                banks [`TC_NUM_BANKS],
  output sram_macro_pkg::word_t   rd_data0,
  output sram_macro_pkg::word_t   rd_data1,
  output logic                    rd_valid0,
  output logic                    rd_valid1
);

  localparam int unsigned SEL_W = $clog2(`TC_NUM_BANKS);

  // One capture register pair per bank
  sram_macro_pkg::word_t dout0_q [`TC_NUM_BANKS];
  sram_macro_pkg::word_t dout1_q [`TC_NUM_BANKS];

  logic             in_range;
  logic [SEL_W-1:0] sel;

  for (genvar g = 0; g < `TC_NUM_BANKS; g++) begin : cap_g
    always_ff @(posedge clk) begin
      if (reset) begin
        dout0_q[g] <= '0;
        dout1_q[g] <= '0;
      end else begin
        dout0_q[g] <= banks[g].dout0;
        dout1_q[g] <= banks[g].dout1;
      end
    end
  end

  // Chip selects past the last bank name nothing
  assign in_range = (cmd.chip_select < `TC_CS_W'(`TC_NUM_BANKS));
  assign sel      = cmd.chip_select[SEL_W-1:0];

  assign rd_data0  = in_range ? dout0_q[sel] : '0;
  assign rd_data1  = in_range ? dout1_q[sel] : '0;
  assign rd_valid0 = in_range && cmd.p0.web;  // Port 0 set to read
  assign rd_valid1 = in_range && !cmd.p1.csb; // Port 1 enabled

endmodule

`default_nettype wire

/* design/sram_bank.sv */
`default_nettype none
`timescale 1ns/1ps

`include "testchip_params.svh"

module sram_bank (
  input  logic     clk,
  input  logic     reset,
  sram_port_if.mem port
);

  // Storage, contents undefined after reset
  sram_macro_pkg::word_t mem [sram_macro_pkg::DEPTH];

  logic wr0;
  logic rd0;
  logic rd1;

  assign wr0 = !port.csb0 && !port.web0;
  assign rd0 = !port.csb0 && port.web0;
  assign rd1 = !port.csb1;

  // Byte-masked write on port 0
  always_ff @(posedge clk) begin
    if (wr0) begin
      for (int b = 0; b < sram_macro_pkg::NUM_BYTES; b++) begin
        if (port.wmask0[b]) begin
          mem[port.addr0][b*8 +: 8] <= port.din0[b*8 +: 8];
        end
      end
    end
  end

  // Port 0 read data, held on write or idle
  always_ff @(posedge clk) begin
    if (reset) begin
      port.dout0 <= '0;
    end else if (rd0) begin
      port.dout0 <= mem[port.addr0];
    end
  end

  // Port 1 read data
  // A same-cycle write on port 0 to this address shows the old word
  always_ff @(posedge clk) begin
    if (reset) begin
      port.dout1 <= '0;
    end else if (rd1) begin
      port.dout1 <= mem[port.addr1];
    end
  end

endmodule

`default_nettype wire

/* design/sram_cmd_pkg.sv */
`default_nettype none

`include "testchip_params.svh"

package sram_cmd_pkg;

  // Address field as carried in the command word, wider than any bank
  localparam int unsigned CMD_ADDR_W = 16;
  localparam int unsigned CMD_MASK_W = `TC_DATA_W / 8;

  // One port's worth of command, 54 bits
  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic [`TC_DATA_W-1:0] din;   // Write data, or read data after a memory load
    logic                  csb;   // Active low chip select
    logic                  web;   // High means read
    logic [CMD_MASK_W-1:0] wmask; // One bit per byte
  } port_cmd_t;

  // Full 112-bit command, MSB first
  typedef struct packed {
    logic [`TC_CS_W-1:0] chip_select;
    port_cmd_t           p0; // Read/write port
    port_cmd_t           p1; // Read-only port
  } cmd_word_t;

  // Out-of-range bank and both ports idle
  localparam cmd_word_t CMD_RESET = '{
    chip_select: {`TC_CS_W{1'b1}},
    p0: '{addr: '0, din: '0, csb: 1'b1, web: 1'b0, wmask: '0},
    p1: '{addr: '0, din: '0, csb: 1'b1, web: 1'b0, wmask: '0}
  };

endpackage

`default_nettype wire

/* design/sram_macro_pkg.sv */
`default_nettype none

`include "testchip_params.svh"

package sram_macro_pkg;

  // Bytes per data word, sets the write mask width
  localparam int unsigned NUM_BYTES = `TC_DATA_W / 8;

  // Words per bank
  localparam int unsigned DEPTH = 2 ** `TC_BANK_AW;

  // One memory word
  typedef logic [`TC_DATA_W-1:0] word_t;

  // Byte write enables, high writes that byte
  typedef logic [NUM_BYTES-1:0] wmask_t;

  // Address inside one bank
  typedef logic [`TC_BANK_AW-1:0] bank_addr_t;

endpackage

`default_nettype wire

/* design/sram_port_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface sram_port_if;

  // Port 0, read/write
  logic                       csb0;
  logic                       web0;
  sram_macro_pkg::wmask_t     wmask0;
  sram_macro_pkg::bank_addr_t addr0;
  sram_macro_pkg::word_t      din0;
  sram_macro_pkg::word_t      dout0;

  // Port 1, read only
  logic                       csb1;
  sram_macro_pkg::bank_addr_t addr1;
  sram_macro_pkg::word_t      dout1;

  // Command side drives the controls
  modport ctrl (output csb0, web0, wmask0, addr0, din0, csb1, addr1);

  // Bank side
  modport mem (
    input  csb0, web0, wmask0, addr0, din0, csb1, addr1,
    output dout0, dout1
  );

  // Read data observer
  modport mon (input dout0, dout1);

endinterface

`default_nettype wire

/* design/sram_testchip_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "testchip_params.svh"

module sram_testchip_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  scan_en,
  input  logic                  scan_in,
  input  logic                  par_load,
  input  logic [`TC_CMD_W-1:0]  par_bits,
  input  logic                  mem_load,
  output logic                  scan_out,
  output logic [`TC_DATA_W-1:0] data0,
  output logic [`TC_DATA_W-1:0] data1
);

  // Current command, seen by the capture mux
  sram_cmd_pkg::cmd_word_t cmd;

  // Selected bank's captured read data
  sram_macro_pkg::word_t rd_data0;
  sram_macro_pkg::word_t rd_data1;
  logic                  rd_valid0;
  logic                  rd_valid1;

  // One port bundle per bank
  sram_port_if bank_if [`TC_NUM_BANKS] ();

  cmd_shift_reg cmd0 (
    .clk       (clk),
    .reset     (reset),
    .scan_en   (scan_en),
    .scan_in   (scan_in),
    .par_load  (par_load),
    .par_bits  (par_bits),
    .mem_load  (mem_load),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1),
    .rd_valid0 (rd_valid0),
    .rd_valid1 (rd_valid1),
    .cmd       (cmd),
    .scan_out  (scan_out),
    .data0     (data0),
    .data1     (data1),
    .banks     (bank_if)
  );

  for (genvar g = 0; g < `TC_NUM_BANKS; g++) begin : bank_g
    sram_bank bank0 (
      .clk   (clk),
      .reset (reset),
      .port  (bank_if[g])
    );
  end

  // Registers all bank outputs, picks the selected one
  read_capture cap0 (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .banks     (bank_if),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1),
    .rd_valid0 (rd_valid0),
    .rd_valid1 (rd_valid1)
  );

endmodule

`default_nettype wire

/* design/testchip_params.svh */
`ifndef TESTCHIP_PARAMS_SVH
`define TESTCHIP_PARAMS_SVH

// Number of SRAM banks behind the command register
`define TC_NUM_BANKS 4

// Data word of every bank port
`define TC_DATA_W 32

// Local bank address, 256 words deep
`define TC_BANK_AW 8

// Full command word: chip select plus two port fields
`define TC_CMD_W 112

// Chip select field, wide enough to name out-of-range banks
`define TC_CS_W 4

`endif

/* files.f */
+incdir+design
design/sram_macro_pkg.sv
design/sram_cmd_pkg.sv
design/sram_port_if.sv
design/cmd_shift_reg.sv
design/sram_bank.sv
design/read_capture.sv
design/sram_testchip_top.sv
verif/sram_testchip_chk.sv
verif/sram_testchip_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SRAM test chip testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module sram_testchip_tb \
  -f files.f \
  -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
echo "Simulation finished without failure"

/* verif/sram_testchip_chk.sv */
`default_nettype none
`timescale 1ns/1ps

`include "testchip_params.svh"

module sram_testchip_chk (
  input logic  clk,
  input logic  reset,
  sram_port_if banks [`TC_NUM_BANKS]
);

  logic [`TC_NUM_BANKS-1:0] csb0_v;
  logic [`TC_NUM_BANKS-1:0] csb1_v;

  for (genvar g = 0; g < `TC_NUM_BANKS; g++) begin : tap_g
    assign csb0_v[g] = banks[g].csb0;
    assign csb1_v[g] = banks[g].csb1;

    // Two back-to-back port 1 reads of one word agree when port 0 writes nothing
    a_p1_no_write: assert property (@(posedge clk) disable iff (reset)
      (!banks[g].csb1 && (banks[g].csb0 || banks[g].web0))
      ##1 (!banks[g].csb1 && $stable(banks[g].addr1))
      |=> $stable(banks[g].dout1))
      else $error("Port 1 read on bank %0d changed the stored word", g);
  end

  // Decode selects one bank at most
  a_one_csb0: assert property (@(posedge clk) disable iff (reset)
    $onehot0(~csb0_v))
    else $error("More than one bank has port 0 selected");

  a_reset_idle: assert property (@(posedge clk)
    reset |=> (&csb0_v && &csb1_v))
    else $error("Chip selects not all inactive after reset");

endmodule

bind sram_testchip_top sram_testchip_chk chk0 (
  .clk   (clk),
  .reset (reset),
  .banks (bank_if)
);

`default_nettype wire

/* verif/sram_testchip_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "testchip_params.svh"

module sram_testchip_tb;

  localparam int NB      = `TC_NUM_BANKS;
  localparam int DEPTH   = 1 << `TC_BANK_AW;
  localparam int TIMEOUT = 2500; // Tests run about 2000 cycles

  logic                  clk;
  logic                  reset;
  logic                  scan_en;
  logic                  scan_in;
  logic                  par_load;
  logic [`TC_CMD_W-1:0]  par_bits;
  logic                  mem_load;
  logic                  scan_out;
  logic [`TC_DATA_W-1:0] data0;
  logic [`TC_DATA_W-1:0] data1;

  sram_cmd_pkg::cmd_word_t cur;   // Expected command register
  logic [`TC_DATA_W-1:0]   shadow [NB][DEPTH];
  int                      known_bank [$]; // Locations with defined contents
  int                      known_addr [$];
  int                      seed = 45;
  int                      cycle_count = 0;
  event                    check_ev;

  sram_testchip_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .scan_en  (scan_en),
    .scan_in  (scan_in),
    .par_load (par_load),
    .par_bits (par_bits),
    .mem_load (mem_load),
    .scan_out (scan_out),
    .data0    (data0),
    .data1    (data1)
  );

  always #10 clk = ~clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      fail_run("Timeout, the tests did not finish within the cycle limit");
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = rand32();
    return int'(r % 32'(n));
  endfunction

  // Idle word, bank 15 and both ports off
  function automatic sram_cmd_pkg::cmd_word_t reset_word();
    sram_cmd_pkg::cmd_word_t w;
    w = '0;
    w.chip_select = '1;
    w.p0.csb = 1'b1;
    w.p1.csb = 1'b1;
    return w;
  endfunction

  function automatic sram_cmd_pkg::port_cmd_t random_port(input logic csb, input logic web);
    sram_cmd_pkg::port_cmd_t p;
    logic [31:0] r;
    r = rand32();
    p.addr = r[15:0]; // Upper byte is ignored by the banks
    p.din = rand32();
    p.csb = csb;
    p.web = web;
    p.wmask = r[19:16];
    return p;
  endfunction

  function automatic sram_cmd_pkg::cmd_word_t make_write(input int bank,
      input logic [15:0] addr, input logic [31:0] data, input logic [3:0] mask);
    sram_cmd_pkg::cmd_word_t w;
    logic [31:0] r;
    r = rand32();
    w.chip_select = `TC_CS_W'(bank);
    w.p0 = random_port(1'b0, 1'b0);
    w.p0.addr = addr;
    w.p0.din = data;
    w.p0.wmask = mask;
    w.p1 = random_port(1'b1, r[0]);
    return w;
  endfunction

  function automatic sram_cmd_pkg::cmd_word_t make_read(input int bank,
      input logic [15:0] addr0, input logic [15:0] addr1, input logic p1_on);
    sram_cmd_pkg::cmd_word_t w;
    logic [31:0] r;
    r = rand32();
    w.chip_select = `TC_CS_W'(bank);
    w.p0 = random_port(1'b0, 1'b1);
    w.p0.addr = addr0;
    w.p1 = random_port(!p1_on, r[0]); // Port 1 web is a don't care
    w.p1.addr = addr1;
    return w;
  endfunction

  // Bank write at an edge, from the word held before it
  function automatic void model_write(input sram_cmd_pkg::cmd_word_t w);
    int bank;
    bank = int'(w.chip_select);
    if (bank < NB && !w.p0.csb && !w.p0.web) begin
      for (int b = 0; b < `TC_DATA_W / 8; b++) begin
        if (w.p0.wmask[b]) begin
          shadow[bank][w.p0.addr[`TC_BANK_AW-1:0]][b*8 +: 8] = w.p0.din[b*8 +: 8];
        end
      end
    end
  endfunction

  // Word after mem_load, with the read held for three cycles
  function automatic sram_cmd_pkg::cmd_word_t expected_word(
      input sram_cmd_pkg::cmd_word_t w);
    sram_cmd_pkg::cmd_word_t e;
    int bank;
    e = w;
    bank = int'(w.chip_select);
    if (bank < NB) begin
      if (w.p0.web) begin
        e.p0.din = shadow[bank][w.p0.addr[`TC_BANK_AW-1:0]];
      end
      if (!w.p1.csb) begin
        e.p1.din = shadow[bank][w.p1.addr[`TC_BANK_AW-1:0]];
      end
    end
    return e;
  endfunction

  always @(check_ev) begin
    assert (data0 === cur.p0.din)
      else fail_run($sformatf("Fail at time %0t: data0 is %h, expected %h",
        $time, data0, cur.p0.din));
    assert (data1 === cur.p1.din)
      else fail_run($sformatf("Fail at time %0t: data1 is %h, expected %h",
        $time, data1, cur.p1.din));
    assert (scan_out === cur[`TC_CMD_W-1])
      else fail_run($sformatf("Fail at time %0t: scan_out is %b, expected %b",
        $time, scan_out, cur[`TC_CMD_W-1]));
  end

  // Drive on the falling edge, then model the rising edge in between
  task automatic drive_cycle(input logic se, input logic si, input logic pl,
      input sram_cmd_pkg::cmd_word_t pb, input logic ml);
    scan_en  = se;
    scan_in  = si;
    par_load = pl;
    par_bits = pb;
    mem_load = ml;
    @(negedge clk);
    model_write(cur);
    if (se) begin
      cur = sram_cmd_pkg::cmd_word_t'({cur[`TC_CMD_W-2:0], si});
    end else if (pl) begin
      cur = pb;
    end else if (ml) begin
      cur = expected_word(cur);
    end
    -> check_ev;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, cur, 1'b0);
  endtask

  task automatic write_word(input sram_cmd_pkg::cmd_word_t w);
    drive_cycle(1'b0, 1'b0, 1'b1, w, 1'b0);
    idle(1); // Bank writes here
  endtask

  task automatic read_check(input sram_cmd_pkg::cmd_word_t w);
    drive_cycle(1'b0, 1'b0, 1'b1, w, 1'b0);
    idle(2);
    drive_cycle(1'b0, 1'b0, 1'b0, w, 1'b1); // Sampled at the fourth edge
  endtask

  initial begin
    logic [15:0]          addr;
    logic [15:0]          addr_b;
    logic [127:0]         rnd;
    logic [`TC_CMD_W-1:0] nw;
    int                   bank;
    int                   idx;
    int                   bad;

    clk      = 1'b0;
    reset    = 1'b1;
    scan_en  = 1'b0;
    scan_in  = 1'b0;
    par_load = 1'b0;
    par_bits = '0;
    mem_load = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    cur = reset_word();
    -> check_ev;

    // Memory load from the out-of-range reset word
    drive_cycle(1'b0, 1'b0, 1'b0, cur, 1'b1);
    idle(3);

    // Full-word writes, each read back on port 0
    repeat (150) begin
      bank = rand_below(NB);
      addr = 16'(rand32());
      write_word(make_write(bank, addr, rand32(), 4'hF));
      known_bank.push_back(bank);
      known_addr.push_back(int'(addr));
      read_check(make_read(bank, addr, 16'(rand32()), 1'b0));
    end

    // Partial byte masks over known words
    repeat (60) begin
      idx = rand_below(known_bank.size());
      write_word(make_write(known_bank[idx], 16'(known_addr[idx]), rand32(),
        4'(1 + rand_below(14))));
      read_check(make_read(known_bank[idx], 16'(known_addr[idx]), 16'(rand32()), 1'b0));
    end

    // Both ports read one bank, every third pass leaves port 1 off
    for (int i = 0; i < 30; i++) begin
      bank   = rand_below(NB);
      addr   = 16'(rand32());
      addr_b = 16'(rand32());
      write_word(make_write(bank, addr, rand32(), 4'hF));
      write_word(make_write(bank, addr_b, rand32(), 4'hF));
      read_check(make_read(bank, addr, addr_b, (i % 3) != 0));
    end

    // Scan in random words, MSB first
    repeat (2) begin
      rnd = {rand32(), rand32(), rand32(), rand32()};
      nw  = rnd[`TC_CMD_W-1:0];
      for (int i = `TC_CMD_W - 1; i >= 0; i--) begin
        drive_cycle(1'b1, nw[i], 1'b0, cur, 1'b0);
      end
      idle(2);
    end

    // Out-of-range chip selects touch no bank
    repeat (8) begin
      addr = 16'(rand32());
      for (int b = 0; b < NB; b++) begin
        write_word(make_write(b, addr, rand32(), 4'hF));
      end
      bad = NB + rand_below(16 - NB);
      write_word(make_write(bad, addr, rand32(), 4'hF));
      for (int b = 0; b < NB; b++) begin
        read_check(make_read(b, addr, addr, 1'b1));
      end
      read_check(make_read(bad, addr, addr, 1'b1));
    end

    idle(2);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
